//--- bnn_accel.f
// Package first, then RTL leaf blocks, top level and testbench
verilog/bnn_pkg.sv
verilog/spi_peripheral.sv
verilog/image_buffer.sv
verilog/bnn_core.sv
verilog/bnn_controller.sv
verilog/bnn_accel_top.sv
testbench/tb_bnn_accel.sv

//--- testbench/tb_bnn_accel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BNN accelerator testbench: SPI host, LFSR images, reference
// classifier, queued compare process and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_bnn_accel;
  import bnn_pkg::*;

  localparam int IMG_BYTES    = IMG_BYTES_DEF;
  localparam int NUM_CLASSES  = NUM_CLASSES_DEF;
  localparam int HALF_SCLK    = 8;                  // clk cycles per sclk phase
  localparam int BYTE_CYCLES  = 16 * HALF_SCLK;     // One SPI byte
  localparam int INFER_CYCLES = NUM_CLASSES * (IMG_BYTES + 1) + 1;
  localparam int MAX_POLLS    = 2 * (INFER_CYCLES / BYTE_CYCLES + 2);
  localparam int EXTRA_POLLS  = 2;                  // Dummies after the result
  localparam int FRAME_CYCLES = (IMG_BYTES + MAX_POLLS + EXTRA_POLLS) * BYTE_CYCLES
                                + INFER_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * 8 * FRAME_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd52802;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;     // x^16+x^14+x^13+x^11+1

  logic        clk;
  logic        rst_n;
  logic        sclk;
  logic        copi;
  logic        cs_n;
  logic        cipo;
  bnn_result_t result;

  logic [7:0]  img [IMG_BYTES];  // Image being sent, MSB = first pixel
  logic [15:0] lfsr;
  int          err_cnt;
  int          check_cnt;

  // Pending checks, filled by stimulus, drained by the compare process
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       name_q [$];
  time         time_q [$];

  bnn_accel_top #(.IMG_BYTES(IMG_BYTES), .NUM_CLASSES(NUM_CLASSES)) DUT (
    .clk(clk), .rst_n(rst_n), .sclk(sclk), .copi(copi), .cs_n(cs_n),
    .cipo(cipo), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;      // 20 ns period
  end

  // Galois step, returns the bit shifted out
  function automatic logic lfsr_next();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ LFSR_TAPS;
    return out;
  endfunction

  // Expected argmax: pixel p agrees with bit 3 of p*(2k+1), lowest k on tie
  function automatic void ref_classify(output int cls, output int score);
    int best;
    int s;
    int pix;
    int w;
    best = -1;
    cls  = 0;
    for (int k = 0; k < NUM_CLASSES; k++) begin
      s = 0;
      for (int p = 0; p < IMG_BYTES * 8; p++) begin
        pix = img[p / 8][7 - (p % 8)];      // First pixel sits in bit 7
        w   = ((p * (2 * k + 1)) >> 3) & 1;
        if (pix == w)
          s++;
      end
      if (s > best) begin
        best = s;
        cls  = k;
      end
    end
    score = best;
  endfunction

  task automatic fill_const(input logic [7:0] value);
    for (int b = 0; b < IMG_BYTES; b++)
      img[b] = value;
  endtask

  task automatic fill_random();
    for (int b = 0; b < IMG_BYTES; b++)
      for (int j = 7; j >= 0; j--)
        img[b][j] = lfsr_next();           // One step per pixel
  endtask

  // Queue one comparison for the compare process
  task automatic post_check(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    got_q.push_back(got);
    exp_q.push_back(exp);
    name_q.push_back(name);
    time_q.push_back($time);
  endtask

  task automatic drain_checks();
    while (got_q.size() != 0)
      @(negedge clk);
  endtask

  // Mode 0 host: copi set while sclk low, cipo sampled at the rising edge
  task automatic spi_xfer(input logic [7:0] mosi, output logic [7:0] miso);
    for (int i = 7; i >= 0; i--) begin
      copi = mosi[i];
      repeat (HALF_SCLK) @(negedge clk);
      sclk    = 1'b1;
      miso[i] = cipo;                      // Launched a half period ago
      repeat (HALF_SCLK) @(negedge clk);
      sclk = 1'b0;
    end
  endtask

  // Full frame: image, polling, result checks, deselect
  task automatic run_frame(input int test_no, input string label);
    logic [7:0] got;
    int         exp_cls;
    int         exp_score;
    int         polls;
    int         err_before;
    bit         ready;
    err_before = err_cnt;
    ref_classify(exp_cls, exp_score);
    cs_n = 1'b0;
    repeat (HALF_SCLK) @(negedge clk);
    for (int b = 0; b < IMG_BYTES; b++) begin
      spi_xfer(img[b], got);
      if (b == 0)
        post_check("cipo first byte", got, 8'h00);
      else
        post_check("cipo image byte", got, 8'h00);
    end
    polls = 0;
    ready = 1'b0;
    while (!ready && polls < MAX_POLLS) begin
      spi_xfer(8'hA5, got);                // Dummy, must be ignored
      polls++;
      if (got[7])
        ready = 1'b1;
      else
        post_check("cipo poll byte", got, 8'h00);
    end
    if (!ready) begin
      $display("%s: no result byte after %0d polled bytes at %0t ns",
               label, polls, $time);
      err_cnt++;
    end else begin
      post_check("cipo result byte", got, 8'h80 + exp_cls);
      post_check("result.valid", result.valid, 1);
      post_check("result.cls", result.cls, exp_cls);
      post_check("result.score", result.score, exp_score);
      for (int i = 0; i < EXTRA_POLLS; i++) begin
        spi_xfer(8'h3C, got);              // Stray bytes after the frame
        post_check("cipo extra byte", got, 8'h80 + exp_cls);
      end
      post_check("result.cls", result.cls, exp_cls);
      post_check("result.score", result.score, exp_score);
    end
    cs_n = 1'b1;
    repeat (8) @(negedge clk);           // Sync, CLEAR and back to IDLE
    post_check("result.valid after cs_n rise", result.valid, 0);
    drain_checks();
    if (err_cnt == err_before)
      $display("test %0d %s: class %0d score %0d, pass",
               test_no, label, exp_cls, exp_score);
    else
      $display("test %0d %s: fail, %0d errors", test_no, label, err_cnt - err_before);
  endtask

  // Compare process
  initial begin : compare
    logic [31:0] g;
    logic [31:0] e;
    string       n;
    time         t;
    forever begin
      @(negedge clk);
      while (got_q.size() != 0) begin
        g = got_q.pop_front();
        e = exp_q.pop_front();
        n = name_q.pop_front();
        t = time_q.pop_front();
        check_cnt++;
        if (g !== e) begin
          $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h", t, n, g, e);
          err_cnt++;
        end
      end
    end
  end

  // Watchdog sized from frame length and inference latency
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int test_no;
    int err_before;
    rst_n     = 1'b0;
    sclk      = 1'b0;
    copi      = 1'b0;
    cs_n      = 1'b1;
    lfsr      = LFSR_SEED;
    err_cnt   = 0;
    check_cnt = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // Idle outputs straight after reset
    test_no    = 1;
    err_before = err_cnt;
    post_check("result.valid", result.valid, 0);
    post_check("cipo", cipo, 0);
    drain_checks();
    if (err_cnt == err_before)
      $display("test %0d reset state: pass", test_no);
    else
      $display("test %0d reset state: fail", test_no);

    test_no++;
    fill_const(8'hFF);
    run_frame(test_no, "all-ones image");
    test_no++;
    fill_const(8'h00);
    run_frame(test_no, "all-zeros image");

    // Back-to-back random frames also cover the clear between frames
    for (int i = 0; i < 5; i++) begin
      test_no++;
      fill_random();
      run_frame(test_no, $sformatf("random image %0d", i));
    end

    drain_checks();
    $display("tests: %0d, checks: %0d, errors: %0d", test_no, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- verilog/bnn_accel_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BNN accelerator top: SPI slave, image buffer, scorer and controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bnn_accel_top #(
  parameter int IMG_BYTES   = bnn_pkg::IMG_BYTES_DEF,
  parameter int NUM_CLASSES = bnn_pkg::NUM_CLASSES_DEF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sclk,
  input  logic                 copi,
  input  logic                 cs_n,
  output logic                 cipo,
  output bnn_pkg::bnn_result_t result
);
  import bnn_pkg::*;

  spi_byte_t   rx;
  logic [7:0]  tx_byte;
  logic        wr_en, clear, start, done;
  logic        full, empty;
  logic [6:0]  rd_addr;
  logic [7:0]  rd_data;
  bnn_result_t score_result;

  spi_peripheral #(.SYNC_STAGES(2)) u_spi (
    .clk(clk), .rst_n(rst_n), .sclk(sclk), .copi(copi), .cs_n(cs_n),
    .tx_byte(tx_byte), .cipo(cipo), .rx(rx)
  );

  image_buffer #(.IMG_BYTES(IMG_BYTES)) u_buf (
    .clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_data(rx.data), .clear(clear),
    .rd_addr(rd_addr), .rd_data(rd_data), .full(full), .empty(empty)
  );

  bnn_core #(.IMG_BYTES(IMG_BYTES), .NUM_CLASSES(NUM_CLASSES)) u_core (
    .clk(clk), .rst_n(rst_n), .start(start), .rd_addr(rd_addr),
    .done(done), .score_result(score_result), .rd_data(rd_data)
  );

  bnn_controller u_ctrl (
    .clk(clk), .rst_n(rst_n), .rx(rx), .full(full), .empty(empty), .done(done),
    .score_result(score_result), .wr_en(wr_en), .clear(clear), .start(start),
    .tx_byte(tx_byte), .result(result)
  );

endmodule

//--- verilog/bnn_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame FSM: image receive, inference, result return, buffer clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bnn_controller (
  input  logic                 clk,
  input  logic                 rst_n,
  input  bnn_pkg::spi_byte_t   rx,
  input  logic                 full,
  input  logic                 empty,
  input  logic                 done,
  input  bnn_pkg::bnn_result_t score_result,
  output logic                 wr_en,
  output logic                 clear,
  output logic                 start,
  output logic [7:0]           tx_byte,
  output bnn_pkg::bnn_result_t result
);
  import bnn_pkg::*;

  ctrl_state_t state, next_state;
  logic        enter_clear;
  logic        cs_active;   // Synchronized chip select

  assign cs_active   = rx.cs_active;
  assign enter_clear = (state != CLEAR) && (next_state == CLEAR);

  // Only image bytes go to the buffer, polls are ignored
  assign wr_en = rx.valid && (state == IMG_RX);

  always_comb begin
    next_state = state;
    case (state)
      IDLE:      if (cs_active) next_state = IMG_RX;
      IMG_RX: begin
        if (full)
          next_state = INFERENCE;
        else if (!cs_active)
          next_state = CLEAR;          // Host gave up mid-frame
      end
      INFERENCE: if (done) next_state = RESULT_TX;
      RESULT_TX: if (!cs_active) next_state = CLEAR;
      CLEAR:     if (empty) next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      start   <= 1'b0;
      clear   <= 1'b0;
      tx_byte <= 8'h00;
      result  <= '0;
    end else begin
      state <= next_state;
      start <= (state == IMG_RX) && (next_state == INFERENCE); // One cycle after full
      clear <= enter_clear;                                    // First CLEAR cycle only

      if (state == INFERENCE && done) begin
        result  <= score_result;
        tx_byte <= {4'h8, score_result.cls};   // 0x80 + class
      end else if (next_state != RESULT_TX) begin
        tx_byte <= 8'h00;                      // Not ready yet
      end

      if (enter_clear)
        result.valid <= 1'b0;
    end
  end

endmodule

//--- verilog/bnn_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequential XNOR-popcount scorer over all classes with argmax
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bnn_core #(
  parameter int IMG_BYTES   = bnn_pkg::IMG_BYTES_DEF,
  parameter int NUM_CLASSES = bnn_pkg::NUM_CLASSES_DEF
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  output logic [6:0]           rd_addr,
  output logic                 done,
  output bnn_pkg::bnn_result_t score_result,
  input  logic [7:0]           rd_data
);
  import bnn_pkg::*;

  logic               busy;
  logic [3:0]         cls;        // Class being scored
  logic [6:0]         step;       // 0..IMG_BYTES, one spare for read latency
  logic [SCORE_W-1:0] acc;        // Partial score of current class
  logic [SCORE_W-1:0] best_score;
  logic [3:0]         best_cls;
  logic               res_valid;
  logic [6:0]         byte_idx;   // Byte whose data is on rd_data
  logic [7:0]         wbyte;
  logic [7:0]         match;
  logic [SCORE_W-1:0] sum;
  logic               last_step;
  logic               last_cls;

  // Step s reads byte s and consumes byte s-1
  assign rd_addr   = (step < 7'(IMG_BYTES)) ? step : 7'd0;
  assign byte_idx  = (step == 7'd0) ? 7'd0 : step - 7'd1;
  assign last_step = (step == 7'(IMG_BYTES));
  assign last_cls  = (cls == 4'(NUM_CLASSES - 1));

  always_comb begin
    wbyte = weight_byte(int'(cls), int'(byte_idx));
    match = ~(rd_data ^ wbyte);                     // 1 where pixel agrees
    sum   = acc + SCORE_W'($countones(match));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      cls        <= 4'd0;
      step       <= 7'd0;
      acc        <= '0;
      best_score <= '0;
      best_cls   <= 4'd0;
      res_valid  <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy       <= 1'b1;
        cls        <= 4'd0;
        step       <= 7'd0;
        acc        <= '0;
        best_score <= '0;                 // Class 0 wins any all-zero tie
        best_cls   <= 4'd0;
        res_valid  <= 1'b0;
      end else if (busy) begin
        if (last_step) begin
          // Strictly greater, so the lowest index keeps a tie
          if (sum > best_score) begin
            best_score <= sum;
            best_cls   <= cls;
          end
          acc  <= '0;
          step <= 7'd0;
          if (last_cls) begin
            busy      <= 1'b0;
            done      <= 1'b1;
            res_valid <= 1'b1;
          end else begin
            cls <= cls + 4'd1;
          end
        end else begin
          if (step != 7'd0)
            acc <= sum;                    // Step 0 has no data yet
          step <= step + 7'd1;
        end
      end
    end
  end

  assign score_result.valid = res_valid;
  assign score_result.cls   = best_cls;
  assign score_result.score = best_score;

  // Controller waits for done before any new frame
  a_start_when_idle : assert property (
    @(posedge clk) disable iff (!rst_n) start |-> !busy
  );

endmodule

//--- verilog/bnn_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BNN shared definitions: image sizes, SPI and result words, FSM
// states and the fixed binary weight rule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package bnn_pkg;

  localparam int IMG_PIXELS      = 784;               // 28 x 28 binary image
  localparam int IMG_BYTES_DEF   = IMG_PIXELS / 8;    // 8 pixels per byte
  localparam int NUM_CLASSES_DEF = 10;                // Up to 16 supported
  localparam int SCORE_W         = $clog2(IMG_PIXELS + 1); // Holds 0..784

  // Received SPI byte, plus the synchronized chip-select level
  typedef struct packed {
    logic       cs_active; // cs_n low after sync
    logic       valid;     // One-cycle strobe per byte
    logic [7:0] data;      // MSB first on the wire
  } spi_byte_t;

  // Classification outcome
  typedef struct packed {
    logic               valid;
    logic [3:0]         cls;   // Winning class index
    logic [SCORE_W-1:0] score; // Matching pixel count
  } bnn_result_t;

  // Frame sequencing
  typedef enum logic [2:0] {
    IDLE,
    IMG_RX,
    INFERENCE,
    RESULT_TX,
    CLEAR
  } ctrl_state_t;

  // Weight bits of class k for packed image byte b, bit 7 first in time.
  // Pixel p gets bit 3 of p * (2k + 1)
  function automatic logic [7:0] weight_byte(input int k, input int b);
    logic [7:0] w;
    int         prod;
    for (int j = 0; j < 8; j++) begin
      prod     = (b * 8 + j) * (2 * k + 1);
      w[7 - j] = prod[3]; // j = 0 lands in the MSB
    end
    return w;
  endfunction

endpackage

//--- verilog/image_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packed image store with write counter and registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module image_buffer #(
  parameter int IMG_BYTES = bnn_pkg::IMG_BYTES_DEF
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  logic [7:0] wr_data,
  input  logic       clear,
  input  logic [6:0] rd_addr,
  output logic [7:0] rd_data,
  output logic       full,
  output logic       empty
);

  logic [7:0] mem [IMG_BYTES];
  logic [6:0] wr_ptr;   // Next byte slot, also fill level
  logic       do_write;

  assign full     = (wr_ptr == 7'(IMG_BYTES));
  assign empty    = (wr_ptr == 7'd0);
  assign do_write = wr_en && !full && !clear; // Overflow bytes dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= 7'd0;
    end else if (clear) begin
      wr_ptr <= 7'd0;                  // Old data left, just unreachable
    end else if (do_write) begin
      wr_ptr <= wr_ptr + 7'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write)
      mem[wr_ptr] <= wr_data;
    rd_data <= mem[rd_addr];         // One cycle read latency
  end

  // Controller leaves IMG_RX before the next byte can arrive
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> !full
  );

endmodule

//--- verilog/spi_peripheral.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mode-0 SPI slave: pin synchronizers, byte deserializer, tx serializer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module spi_peripheral #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sclk,
  input  logic                copi,
  input  logic                cs_n,
  input  logic [7:0]          tx_byte,
  output logic                cipo,
  output bnn_pkg::spi_byte_t  rx
);
  import bnn_pkg::*;

  logic [SYNC_STAGES-1:0] sclk_sync;
  logic [SYNC_STAGES-1:0] copi_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic                   sclk_s, copi_s, cs_s;
  logic                   sclk_q;     // Synced sclk, one cycle older
  logic                   cs_q;       // Synced cs_n, one cycle older
  logic                   sclk_rise, sclk_fall;
  logic [2:0]             bit_cnt;    // Bits taken in current byte
  logic [6:0]             rx_sr;      // Bits so far, newest in LSB
  logic [7:0]             rx_data;
  logic                   rx_valid;
  logic [7:0]             tx_sr;      // MSB drives cipo

  assign sclk_s = sclk_sync[SYNC_STAGES-1];
  assign copi_s = copi_sync[SYNC_STAGES-1];
  assign cs_s   = cs_sync[SYNC_STAGES-1];

  assign sclk_rise = sclk_s & ~sclk_q;  // Sample edge in mode 0
  assign sclk_fall = ~sclk_s & sclk_q;  // Launch edge

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= '0;
      copi_sync <= '0;
      cs_sync   <= '1;                   // Deselected
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
      bit_cnt   <= 3'd0;
      rx_valid  <= 1'b0;
      tx_sr     <= 8'h00;
    end else begin
      sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
      copi_sync <= {copi_sync[SYNC_STAGES-2:0], copi};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], cs_n};
      sclk_q    <= sclk_s;
      cs_q      <= cs_s;
      rx_valid  <= 1'b0;
      if (cs_s) begin
        bit_cnt <= 3'd0;                 // Realign on every deselect
      end else begin
        if (cs_q) begin
          tx_sr <= tx_byte;              // cs_n just fell
        end else if (sclk_fall) begin
          // Byte boundary picks up the latest status
          tx_sr <= (bit_cnt == 3'd0) ? tx_byte : {tx_sr[6:0], 1'b0};
        end
        if (sclk_rise) begin
          bit_cnt <= bit_cnt + 3'd1;     // Wraps to 0 after bit 7
          if (bit_cnt == 3'd7)
            rx_valid <= 1'b1;
        end
      end
    end
  end

  // Shift data path
  always_ff @(posedge clk) begin
    if (!cs_s && sclk_rise) begin
      rx_sr <= {rx_sr[5:0], copi_s};
      if (bit_cnt == 3'd7)
        rx_data <= {rx_sr, copi_s};
    end
  end

  assign cipo = tx_sr[7];

  assign rx.cs_active = ~cs_s;
  assign rx.valid     = rx_valid;
  assign rx.data      = rx_data;

  // Deselect must flush any byte in flight
  a_no_valid_deselected : assert property (
    @(posedge clk) disable iff (!rst_n) rx.valid |-> rx.cs_active
  );

endmodule
